//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_harness \
		-f sim.f -Mdir obj_dir -o tb_soc_harness
	./obj_dir/tb_soc_harness | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/apb_addr_decoder.sv
// APB address decoder: region lookup, routing to ROM or SRAM,
// and the local error response for illegal accesses

`timescale 1ns/10ps

`include "soc_cfg.svh"

module apb_addr_decoder import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`SOC_ADDR_WIDTH-1:0] paddr_i,
  input  logic [`SOC_DATA_WIDTH-1:0] pwdata_i,
  input  logic [`SOC_STRB_WIDTH-1:0] pstrb_i,
  output logic [`SOC_DATA_WIDTH-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  apb_if.requester                   rom_bus,
  apb_if.requester                   sram_bus
);

  localparam logic [`SOC_ADDR_WIDTH-1:0] ROM_BASE_W = `ROM_BASE;
  localparam int unsigned OFF_W = `SOC_ADDR_WIDTH - 4;
  localparam logic [OFF_W-1:0] ROM_LIMIT  = OFF_W'(`ROM_WORDS * 4);
  localparam logic [OFF_W-1:0] SRAM_LIMIT = OFF_W'(`SRAM_WORDS * 4);

  paddr_u           addr;
  logic [OFF_W-1:0] rom_off;
  logic             rom_hit;
  logic             sram_hit;
  logic             rom_sel_q;
  logic             sram_sel_q;

  // ------------------------------------------------------------------
  // Region decode
  // ------------------------------------------------------------------
  assign addr    = paddr_i;
  // Offsets below the ROM base wrap and fail the limit check
  assign rom_off = addr.part.offset - ROM_BASE_W[OFF_W-1:0];

  // ROM is read only, a write falls through to the error path
  assign rom_hit  = (addr.part.tag == REGION_ROM) && (rom_off < ROM_LIMIT) && !pwrite_i;
  assign sram_hit = (addr.part.tag == REGION_SRAM) && (addr.part.offset < SRAM_LIMIT);

  // Selection is captured in the setup cycle and steers the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rom_sel_q  <= 1'b0;
      sram_sel_q <= 1'b0;
    end else if (psel_i && !penable_i) begin
      rom_sel_q  <= rom_hit;
      sram_sel_q <= sram_hit;
    end
  end

  // ------------------------------------------------------------------
  // Request routing, psel only to the addressed slave
  // ------------------------------------------------------------------
  assign rom_bus.psel    = psel_i && rom_hit;
  assign rom_bus.penable = penable_i;
  assign rom_bus.pwrite  = pwrite_i;
  assign rom_bus.paddr   = addr;
  assign rom_bus.pwdata  = pwdata_i;
  assign rom_bus.pstrb   = pstrb_i;

  assign sram_bus.psel    = psel_i && sram_hit;
  assign sram_bus.penable = penable_i;
  assign sram_bus.pwrite  = pwrite_i;
  assign sram_bus.paddr   = addr;
  assign sram_bus.pwdata  = pwdata_i;
  assign sram_bus.pstrb   = pstrb_i;

  // ------------------------------------------------------------------
  // Response mux
  // ------------------------------------------------------------------
  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    if (psel_i && penable_i) begin
      if (rom_sel_q) begin
        prdata_o  = rom_bus.prdata;
        pready_o  = rom_bus.pready;
        pslverr_o = rom_bus.pslverr;
      end else if (sram_sel_q) begin
        prdata_o  = sram_bus.prdata;
        pready_o  = sram_bus.pready;
        pslverr_o = sram_bus.pslverr;
      end else begin
        // Unmapped, GPIO, out of range or ROM write
        pready_o  = 1'b1;
        pslverr_o = 1'b1;
      end
    end
  end

endmodule

//--- design/apb_if.sv
// APB bus interface with requester and completer modports

`timescale 1ns/10ps

`include "soc_cfg.svh"

interface apb_if import soc_pkg::*; ();

  // Request side
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  paddr_u                     paddr;
  logic [`SOC_DATA_WIDTH-1:0] pwdata;
  logic [`SOC_STRB_WIDTH-1:0] pstrb;

  // Response side, valid while pready is high
  logic [`SOC_DATA_WIDTH-1:0] prdata;
  logic                       pready;
  logic                       pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

//--- design/apb_sram.sv
// Main SRAM APB completer with byte strobes, zero wait states
// and wrapping read and write beat counters

`timescale 1ns/10ps

`include "soc_cfg.svh"

module apb_sram import soc_pkg::*; #(
  parameter int unsigned NUM_WORDS = `SRAM_WORDS
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  apb_if.completer  bus,
  output count_t    rd_count_o,
  output count_t    wr_count_o
);

  localparam int unsigned IDX_W = $clog2(NUM_WORDS);

  logic [`SOC_DATA_WIDTH-1:0] mem [NUM_WORDS];
  logic [IDX_W-1:0]           idx;
  logic                       access;
  logic                       wr_en;
  logic                       rd_en;
  count_t                     rd_cnt_q;
  count_t                     wr_cnt_q;

  // Word index from the byte offset
  assign idx    = bus.paddr.part.offset[IDX_W+1:2];
  assign access = bus.psel && bus.penable;
  assign wr_en  = access && bus.pwrite;
  assign rd_en  = access && !bus.pwrite;

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < `SOC_STRB_WIDTH; b++) begin
        if (bus.pstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
        end
      end
    end
  end

  // No wait state, every access completes in its first cycle
  assign bus.prdata  = mem[idx];
  assign bus.pready  = access;
  assign bus.pslverr = 1'b0;

  // ------------------------------------------------------------------
  // Beat counters
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      if (rd_en) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
      if (wr_en) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  assign rd_count_o = rd_cnt_q;
  assign wr_count_o = wr_cnt_q;

endmodule

//--- design/boot_rom.sv
// Boot ROM APB completer, read only, one wait state

`timescale 1ns/10ps

`include "soc_cfg.svh"

module boot_rom (
  input  logic     clk_i,
  input  logic     rst_ni,
  apb_if.completer bus
);

  localparam int unsigned IDX_W = $clog2(`ROM_WORDS);

  logic [`SOC_DATA_WIDTH-1:0] rom_table [`ROM_WORDS];
  logic [`SOC_DATA_WIDTH-1:0] rdata_q;
  logic [IDX_W-1:0]           idx;
  logic                       ready_q;

  // Word k holds the signature above its own index
  always_comb begin
    for (int k = 0; k < `ROM_WORDS; k++) begin
      rom_table[k] = {`ROM_SIGNATURE, 16'(k)};
    end
  end

  // ROM base is aligned well above the ROM size
  assign idx = bus.paddr.raw[IDX_W+1:2];

  // First access cycle loads the data, second one completes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
    end else if (ready_q) begin
      ready_q <= 1'b0;
    end else if (bus.psel && bus.penable) begin
      ready_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.psel && bus.penable && !ready_q) begin
      rdata_q <= rom_table[idx];
    end
  end

  assign bus.prdata  = rdata_q;
  assign bus.pready  = ready_q;
  assign bus.pslverr = 1'b0;

endmodule

//--- design/reset_debug_ctrl.sv
// Peripheral reset synchronizer and the startup gate
// for external debug requests

`timescale 1ns/10ps

`include "soc_cfg.svh"

module reset_debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic periph_rst_no,
  output logic debug_req_o
);

  localparam int unsigned DLY_W = $clog2(`DEBUG_DELAY_CYCLES + 1);

  logic             comb_rst_n;
  logic [1:0]       sync_q;
  logic [DLY_W-1:0] dly_cnt_q;

  // ------------------------------------------------------------------
  // Peripheral reset
  // ------------------------------------------------------------------
  // Asserts at once, releases two edges after both sources go inactive
  assign comb_rst_n = rst_ni && !ndmreset_i;

  always_ff @(posedge clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign periph_rst_no = sync_q[1];

  // ------------------------------------------------------------------
  // Debug request hold-off
  // ------------------------------------------------------------------
  // Runs on power-on reset only, ndmreset leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_cnt_q <= DLY_W'(`DEBUG_DELAY_CYCLES);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dly_cnt_q == '0) && debug_en_i && debug_req_i;

endmodule

//--- design/soc_cfg.svh
// Width, region map, memory size and debug delay parameters
// for the APB test system

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// APB bus widths
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
`define SOC_STRB_WIDTH 4

// Region map
`define ROM_BASE      32'h0000_1000
`define ROM_WORDS     16
`define ROM_SIGNATURE 16'hB007
`define GPIO_BASE     32'h4000_0000
`define SRAM_BASE     32'h8000_0000
`define SRAM_WORDS    1024

// Debug request hold-off after power-on reset, in cycles
`define DEBUG_DELAY_CYCLES 64

`endif

//--- design/soc_harness.sv
// Top level of the APB test system: reset and debug control,
// address decoder, boot ROM and main SRAM

`timescale 1ns/10ps

`include "soc_cfg.svh"

module soc_harness import soc_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ndmreset_i,
  input  logic                       debug_req_i,
  input  logic                       debug_en_i,
  // External APB requester
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`SOC_ADDR_WIDTH-1:0] paddr_i,
  input  logic [`SOC_DATA_WIDTH-1:0] pwdata_i,
  input  logic [`SOC_STRB_WIDTH-1:0] pstrb_i,
  output logic [`SOC_DATA_WIDTH-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Debug and status
  output logic                       debug_req_o,
  output count_t                     rd_count_o,
  output count_t                     wr_count_o
);

  logic periph_rst_n;

  apb_if rom_bus ();
  apb_if sram_bus ();

  // ------------------------------------------------------------------
  // Reset and debug
  // ------------------------------------------------------------------
  reset_debug_ctrl i_reset_debug_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .debug_req_i   ( debug_req_i  ),
    .debug_en_i    ( debug_en_i   ),
    .periph_rst_no ( periph_rst_n ),
    .debug_req_o   ( debug_req_o  )
  );

  // ------------------------------------------------------------------
  // Region map, in the peripheral reset domain
  // ------------------------------------------------------------------
  apb_addr_decoder i_apb_addr_decoder (
    .clk_i     ( clk_i        ),
    .rst_ni    ( periph_rst_n ),
    .psel_i    ( psel_i       ),
    .penable_i ( penable_i    ),
    .pwrite_i  ( pwrite_i     ),
    .paddr_i   ( paddr_i      ),
    .pwdata_i  ( pwdata_i     ),
    .pstrb_i   ( pstrb_i      ),
    .prdata_o  ( prdata_o     ),
    .pready_o  ( pready_o     ),
    .pslverr_o ( pslverr_o    ),
    .rom_bus   ( rom_bus      ),
    .sram_bus  ( sram_bus     )
  );

  // ------------------------------------------------------------------
  // Memories
  // ------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i  ( clk_i        ),
    .rst_ni ( periph_rst_n ),
    .bus    ( rom_bus      )
  );

  apb_sram #(
    .NUM_WORDS ( `SRAM_WORDS )
  ) i_apb_sram (
    .clk_i      ( clk_i        ),
    .rst_ni     ( periph_rst_n ),
    .bus        ( sram_bus     ),
    .rd_count_o ( rd_count_o   ),
    .wr_count_o ( wr_count_o   )
  );

endmodule

//--- design/soc_pkg.sv
// Shared types: address regions, the two-view APB address word
// and the beat counter type

`include "soc_cfg.svh"

package soc_pkg;

  // Region tag is the top nibble of the address
  typedef enum logic [3:0] {
    REGION_ROM  = 4'h0,
    REGION_GPIO = 4'h4,
    REGION_SRAM = 4'h8
  } region_e;

  typedef struct packed {
    region_e                      tag;
    logic [`SOC_ADDR_WIDTH-5:0]   offset;
  } paddr_part_t;

  // Same address word, either raw or split into tag and byte offset
  typedef union packed {
    logic [`SOC_ADDR_WIDTH-1:0] raw;
    paddr_part_t                part;
  } paddr_u;

  // Completed beat counter, wraps on overflow
  typedef logic [31:0] count_t;

endpackage

//--- sim.f
+incdir+design
design/soc_pkg.sv
design/apb_if.sv
design/apb_addr_decoder.sv
design/apb_sram.sv
design/boot_rom.sv
design/reset_debug_ctrl.sv
design/soc_harness.sv
verif/tb_soc_harness.sv

//--- verif/tb_soc_harness.sv
// Testbench for the APB test system with clock and reset, LFSR stimulus,
// APB transfer tasks, directed tests, watchdog and summary

`timescale 1ns/10ps

`include "soc_cfg.svh"

module tb_soc_harness import soc_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned SAMPLE_DLY = 2;
  localparam int unsigned N_SRAM_OPS = 24;
  // Transfers issued over all tests at four cycles or fewer each
  localparam int unsigned N_XFERS    = 2 * N_SRAM_OPS + `ROM_WORDS + 30;
  localparam int unsigned RUN_CYCLES = 10 + `DEBUG_DELAY_CYCLES + 30 + 4 * N_XFERS;

  logic        clk_i, rst_ni, ndmreset_i, debug_req_i, debug_en_i;
  logic        psel_i, penable_i, pwrite_i;
  logic [31:0] paddr_i, pwdata_i, prdata_o;
  logic [3:0]  pstrb_i;
  logic        pready_o, pslverr_o, debug_req_o;
  count_t      rd_count_o, wr_count_o;

  // Response of the last transfer
  logic [31:0] rsp_data;
  logic        rsp_err;
  int unsigned rsp_waits;

  // SRAM reference model with a flag per written byte
  logic [31:0] sram_model [`SRAM_WORDS];
  logic [3:0]  sram_known [`SRAM_WORDS];

  logic [15:0] lfsr_state;
  int unsigned n_checks;
  int unsigned n_errors;
  count_t      exp_rd;
  count_t      exp_wr;

  soc_harness u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      n_errors++;
    end
  endtask

  // One APB transfer with setup and then access until pready
  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    pstrb_i   = strb;
    @(negedge clk_i);
    penable_i = 1'b1;
    rsp_waits = 0;
    #SAMPLE_DLY;
    while (!pready_o) begin
      @(negedge clk_i);
      #SAMPLE_DLY;
      rsp_waits++;
    end
    rsp_data = prdata_o;
    rsp_err  = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    // Only in-range SRAM beats are counted
    if (addr >= `SRAM_BASE && addr < `SRAM_BASE + `SRAM_WORDS * 4) begin
      if (wr) begin
        exp_wr++;
      end else begin
        exp_rd++;
      end
    end
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    apb_transfer(1'b1, addr, data, strb);
  endtask

  task automatic apb_read(input logic [31:0] addr);
    apb_transfer(1'b0, addr, '0, '0);
  endtask

  task automatic sram_write(input int unsigned idx, input logic [31:0] data,
                            input logic [3:0] strb);
    apb_write(`SRAM_BASE + idx * 4, data, strb);
    check_value("sram write error flag", rsp_err, 0);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        sram_model[idx][8*b +: 8] = data[8*b +: 8];
        sram_known[idx][b] = 1'b1;
      end
    end
  endtask

  // Compares only bytes the model has seen written
  task automatic sram_check(input int unsigned idx);
    logic [31:0] mask;
    apb_read(`SRAM_BASE + idx * 4);
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{sram_known[idx][b]}};
    end
    check_value($sformatf("sram word %0d", idx), rsp_data & mask, sram_model[idx] & mask);
    check_value("sram read error flag", rsp_err, 0);
    check_value("sram wait states", rsp_waits, 0);
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic debug_gating_test();
    #SAMPLE_DLY;
    check_value("pready after reset", pready_o, 0);
    check_value("pslverr after reset", pslverr_o, 0);
    check_value("counters after reset", rd_count_o | wr_count_o, 0);
    for (int c = 0; c < 10; c++) begin
      check_value("debug_req_o in hold-off", debug_req_o, 0);
      @(negedge clk_i);
      #SAMPLE_DLY;
    end
    repeat (`DEBUG_DELAY_CYCLES + 5 - 10) @(negedge clk_i);
    #SAMPLE_DLY;
    check_value("debug_req_o after hold-off", debug_req_o, 1);
    @(negedge clk_i);
    debug_req_i = 1'b0;
    #SAMPLE_DLY;
    check_value("debug_req_o follows request", debug_req_o, 0);
    @(negedge clk_i);
    debug_req_i = 1'b1;
    debug_en_i  = 1'b0;
    #SAMPLE_DLY;
    check_value("debug_req_o while disabled", debug_req_o, 0);
    @(negedge clk_i);
    debug_req_i = 1'b0;
    debug_en_i  = 1'b1;
  endtask

  task automatic sram_data_test();
    int unsigned touched [$];
    int unsigned idx;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < N_SRAM_OPS + 6; i++) begin
      // Last few writes land on words already written
      idx  = (i < N_SRAM_OPS) ? rand_bits(10) : touched[i - N_SRAM_OPS];
      data = rand_bits(32);
      strb = rand_bits(4);
      touched.push_back(idx);
      sram_write(idx, data, strb);
    end
    for (int i = 0; i < N_SRAM_OPS; i++) begin
      sram_check(touched[i]);
    end
  endtask

  task automatic boot_rom_test();
    logic [31:0] exp_word;
    for (int k = 0; k < `ROM_WORDS; k++) begin
      exp_word = (32'(`ROM_SIGNATURE) << 16) | 32'(k);
      apb_read(`ROM_BASE + k * 4);
      check_value($sformatf("rom word %0d", k), rsp_data, exp_word);
      check_value("rom read error flag", rsp_err, 0);
      check_value("rom wait states", rsp_waits, 1);
    end
    apb_write(`ROM_BASE + 12, 32'hDEAD_BEEF, 4'hF);
    check_value("rom write error flag", rsp_err, 1);
    apb_read(`ROM_BASE + 12);
    exp_word = (32'(`ROM_SIGNATURE) << 16) | 32'd3;
    check_value("rom word 3 after write", rsp_data, exp_word);
  endtask

  task automatic error_decode_test();
    logic [31:0] bad [5];
    bad = '{`GPIO_BASE, 32'h2000_0000, `ROM_BASE + `ROM_WORDS * 4, `ROM_BASE - 4,
            `SRAM_BASE + `SRAM_WORDS * 4};
    foreach (bad[i]) begin
      for (int wr = 0; wr < 2; wr++) begin
        apb_transfer(wr[0], bad[i], 32'hFFFF_FFFF, 4'hF);
        check_value($sformatf("error flag at %h", bad[i]), rsp_err, 1);
        check_value($sformatf("error data at %h", bad[i]), rsp_data, 0);
        check_value("error wait states", rsp_waits, 0);
      end
    end
  endtask

  task automatic beat_counter_test();
    sram_write(5, 32'h0102_0304, 4'hF);
    sram_write(6, 32'hA5A5_5A5A, 4'h3);
    sram_check(5);
    apb_read(`ROM_BASE);
    apb_read(`GPIO_BASE + 8);
    apb_write(`SRAM_BASE + `SRAM_WORDS * 4 + 4, 32'h0, 4'hF);
    sram_check(6);
    #SAMPLE_DLY;
    check_value("read beat count", rd_count_o, exp_rd);
    check_value("write beat count", wr_count_o, exp_wr);
  endtask

  task automatic ndm_reset_test();
    sram_write(100, 32'hCAFE_F00D, 4'hF);
    sram_write(101, 32'h1234_5678, 4'hF);
    @(negedge clk_i);
    ndmreset_i = 1'b1;
    repeat (3) @(negedge clk_i);
    ndmreset_i = 1'b0;
    repeat (5) @(negedge clk_i);
    #SAMPLE_DLY;
    check_value("read count after ndmreset", rd_count_o, 0);
    check_value("write count after ndmreset", wr_count_o, 0);
    exp_rd = '0;
    exp_wr = '0;
    // Hold-off counter runs on power-on reset so requests still pass
    @(negedge clk_i);
    debug_req_i = 1'b1;
    #SAMPLE_DLY;
    check_value("debug_req_o after ndmreset", debug_req_o, 1);
    @(negedge clk_i);
    debug_req_i = 1'b0;
    sram_check(100);
    sram_check(101);
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    $display("%-20s done, %0d errors", name, n_errors - errs_before);
  endtask

  // ------------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------------
  initial begin : main
    int unsigned e0;
    rst_ni      = 1'b0;
    ndmreset_i  = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    paddr_i     = '0;
    pwdata_i    = '0;
    pstrb_i     = '0;
    lfsr_state  = 16'd44;
    n_checks    = 0;
    n_errors    = 0;
    exp_rd      = '0;
    exp_wr      = '0;
    foreach (sram_known[i]) begin
      sram_known[i] = 4'h0;
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    e0 = n_errors;
    debug_gating_test();
    report_test("debug gating", e0);
    e0 = n_errors;
    sram_data_test();
    report_test("sram data path", e0);
    e0 = n_errors;
    boot_rom_test();
    report_test("boot rom", e0);
    e0 = n_errors;
    error_decode_test();
    report_test("error decode", e0);
    e0 = n_errors;
    beat_counter_test();
    report_test("beat counters", e0);
    e0 = n_errors;
    ndm_reset_test();
    report_test("ndmreset", e0);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (2 * RUN_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
